//--- sim.f
source/axil_wb_pkg.sv
source/axil_write_join.sv
source/wb_write_master.sv
source/axil_resp_tracker.sv
source/axilwr2wb.sv
tests/axilwr2wb_props.sv
tests/axilwr2wb_tb.sv

//--- Bender.yml
package:
  name: axilwr2wb

sources:
  - source/axil_wb_pkg.sv
  - source/axil_write_join.sv
  - source/wb_write_master.sv
  - source/axil_resp_tracker.sv
  - source/axilwr2wb.sv
  - target: test
    files:
      - tests/axilwr2wb_props.sv
      - tests/axilwr2wb_tb.sv

//--- tests/axilwr2wb_tb.sv
// Table-driven testbench; entries need unique data, the slave answers in order, one per cycle
module axilwr2wb_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int N = 19;

	// One table row, stimulus and expected response
	typedef struct packed {
		logic [axil_wb_pkg::AXI_ADDR_W-1:0] addr;
		logic [axil_wb_pkg::DATA_W-1:0] data;
		logic [axil_wb_pkg::STRB_W-1:0] strb;
		logic signed [7:0] skew;
		logic [7:0] stall;
		logic [7:0] delay;
		logic err;
		logic quiet;
		logic hold;
		axil_wb_pkg::axi_resp_e exp;
	} entry_t;

	entry_t tbl [N];
	int seed = 32'h8011;
	int mism = 0;
	int other = 0;
	// Failures from the bound tracker properties
	int prop_fail = 0;
	int cycles = 0;
	int b_count = 0;
	int bus_idx = 0;
	int stb_count = 0;
	int stall_left = 0;
	bit need_load = 1;
	bit b_hold = 0;
	int due_q [$];
	bit err_q [$];

	logic i_clk, w_reset;
	logic i_axi_awvalid, o_axi_awready, i_axi_wvalid, o_axi_wready;
	logic [axil_wb_pkg::AXI_ADDR_W-1:0] i_axi_awaddr;
	logic [axil_wb_pkg::DATA_W-1:0] i_axi_wdata;
	logic [axil_wb_pkg::STRB_W-1:0] i_axi_wstrb;
	logic o_axi_bvalid, i_axi_bready;
	axil_wb_pkg::axi_resp_e o_axi_bresp;
	logic o_wb_cyc, o_wb_stb, i_wb_ack, i_wb_stall, i_wb_err;
	logic [axil_wb_pkg::WB_ADDR_W-1:0] o_wb_addr;
	logic [axil_wb_pkg::DATA_W-1:0] o_wb_data;
	logic [axil_wb_pkg::STRB_W-1:0] o_wb_sel;

	axilwr2wb dut0 (.*);

	initial
	begin
		i_clk = 1'b0;
		forever #4 i_clk = !i_clk;
	end

	// Fills one row, address offset and data derived from the index
	task automatic add_row(input int i, input int stall, input int delay, input bit err,
		input bit quiet, input bit hold, input axil_wb_pkg::axi_resp_e exp);
		tbl[i].addr = 28'h0004000 + i * 28'h104 + (i % 4);
		tbl[i].data = 32'hC0DE0000 ^ (i * 32'h01010101);
		tbl[i].strb = 4'(i) | 4'h1;
		tbl[i].skew = 8'($random(seed) % 3);
		tbl[i].stall = 8'(stall);
		tbl[i].delay = 8'(delay);
		tbl[i].err = err;
		tbl[i].quiet = quiet;
		tbl[i].hold = hold;
		tbl[i].exp = exp;
	endtask

	function automatic int find_row(input logic [axil_wb_pkg::DATA_W-1:0] data);
		for (int k = 0; k < N; k++)
			if (tbl[k].data == data)
				return k;
		return 0;
	endfunction

	task automatic drive_aw(input int i, input int lead);
		bit done;
		repeat (lead) @(posedge i_clk) #1;
		i_axi_awvalid = 1'b1;
		i_axi_awaddr = tbl[i].addr;
		done = 1'b0;
		while (!done)
		begin
			// Ready here is the value at the coming edge
			done = o_axi_awready;
			@(posedge i_clk) #1;
		end
		i_axi_awvalid = 1'b0;
	endtask

	task automatic drive_w(input int i, input int lead);
		bit done;
		repeat (lead) @(posedge i_clk) #1;
		i_axi_wvalid = 1'b1;
		i_axi_wdata = tbl[i].data;
		i_axi_wstrb = tbl[i].strb;
		done = 1'b0;
		while (!done)
		begin
			done = o_axi_wready;
			@(posedge i_clk) #1;
		end
		i_axi_wvalid = 1'b0;
	endtask

	// Timeout and cycle count
	always @(posedge i_clk)
	begin
		cycles++;
		if (cycles > 40 * N)
		begin
			$display("Timeout after %0d cycles with %0d responses", cycles, b_count);
			$display("Test failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Wishbone slave and bready, driven after the edge
	////////////////////////////////////////////////////////////

	always @(posedge i_clk)
	begin
		#1;
		i_wb_ack = 1'b0;
		i_wb_err = 1'b0;
		if (!w_reset)
		begin
			i_axi_bready = b_hold ? 1'b0 : 1'($random(seed));
			// Fresh strobe loads its stall count
			if (o_wb_stb && need_load)
			begin
				stall_left = tbl[find_row(o_wb_data)].stall;
				need_load = 1'b0;
			end
			i_wb_stall = (stall_left > 0);
			if (stall_left > 0)
				stall_left--;
			if ((due_q.size() > 0) && (cycles >= due_q[0]))
			begin
				if (err_q[0])
				begin
					i_wb_err = 1'b1;
					due_q.delete();
					err_q.delete();
				end
				else
				begin
					i_wb_ack = 1'b1;
					void'(due_q.pop_front());
					void'(err_q.pop_front());
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Monitors at the falling edge
	////////////////////////////////////////////////////////////

	always @(negedge i_clk)
	begin
		int k;
		// Writes the slave still owes an answer keep the cycle open
		if (!w_reset && (due_q.size() > 0))
			assert (o_wb_cyc) else
			begin
				mism++;
				$display("MISMATCH o_wb_cyc got %h exp %h", o_wb_cyc, 1'b1);
			end
		if (!w_reset && o_wb_stb && !i_wb_stall && !i_wb_err)
		begin
			// Flushed writes may be skipped, nothing else
			while ((bus_idx < N - 1) && (tbl[bus_idx].exp == axil_wb_pkg::RESP_DECERR)
				&& (tbl[bus_idx].data != o_wb_data))
				bus_idx++;
			k = bus_idx;
			assert (o_wb_addr == tbl[k].addr >> axil_wb_pkg::ADDR_LSBS) else
			begin
				mism++;
				$display("MISMATCH o_wb_addr got %h exp %h", o_wb_addr,
					tbl[k].addr >> axil_wb_pkg::ADDR_LSBS);
			end
			assert (o_wb_data == tbl[k].data) else
			begin
				mism++;
				$display("MISMATCH o_wb_data got %h exp %h", o_wb_data, tbl[k].data);
			end
			assert (o_wb_sel == tbl[k].strb) else
			begin
				mism++;
				$display("MISMATCH o_wb_sel got %h exp %h", o_wb_sel, tbl[k].strb);
			end
			due_q.push_back(cycles + tbl[k].delay);
			err_q.push_back(tbl[k].err);
			bus_idx++;
			stb_count++;
		end
		if (!o_wb_stb || !i_wb_stall)
			need_load = 1'b1;
		if (!w_reset && o_axi_bvalid && i_axi_bready)
		begin
			assert (b_count < N) else
			begin
				other++;
				$display("Response arrived with no write waiting for it");
			end
			if (b_count < N)
				assert (o_axi_bresp == tbl[b_count].exp) else
				begin
					mism++;
					$display("MISMATCH o_axi_bresp got %h exp %h", o_axi_bresp,
						tbl[b_count].exp);
				end
			b_count++;
		end
	end

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial
	begin
		w_reset = 1'b1;
		i_axi_awvalid = 1'b0;
		i_axi_wvalid = 1'b0;
		i_axi_awaddr = '0;
		i_axi_wdata = '0;
		i_axi_wstrb = '0;
		i_axi_bready = 1'b0;
		i_wb_ack = 1'b0;
		i_wb_stall = 1'b0;
		i_wb_err = 1'b0;
		// Plain, stalled, then eight full plus one blocked
		add_row(0, 0, 0, 0, 0, 0, axil_wb_pkg::RESP_OKAY);
		add_row(1, 2, 1, 0, 0, 0, axil_wb_pkg::RESP_OKAY);
		add_row(2, 1, 2, 0, 0, 0, axil_wb_pkg::RESP_OKAY);
		add_row(3, 3, 0, 0, 0, 0, axil_wb_pkg::RESP_OKAY);
		for (int i = 4; i < 13; i++)
			add_row(i, 0, 3, 0, (i == 4), 1, axil_wb_pkg::RESP_OKAY);
		// Error with two writes behind it, then recovery
		add_row(13, 0, 0, 0, 1, 0, axil_wb_pkg::RESP_OKAY);
		add_row(14, 0, 15, 1, 0, 0, axil_wb_pkg::RESP_SLVERR);
		add_row(15, 0, 0, 0, 0, 0, axil_wb_pkg::RESP_DECERR);
		add_row(16, 0, 0, 0, 0, 0, axil_wb_pkg::RESP_DECERR);
		add_row(17, 1, 1, 0, 1, 0, axil_wb_pkg::RESP_OKAY);
		add_row(18, 0, 0, 0, 0, 0, axil_wb_pkg::RESP_OKAY);
		repeat (3) @(posedge i_clk);
		#1 w_reset = 1'b0;
		assert (!o_wb_cyc && !o_wb_stb && !o_axi_bvalid && o_axi_awready && o_axi_wready
			&& (o_axi_bresp == axil_wb_pkg::RESP_OKAY)) else
		begin
			other++;
			$display("Outputs not in their reset state after reset");
		end
		for (int i = 0; i < N; i++)
		begin
			while (tbl[i].quiet && (b_count < i))
				@(posedge i_clk) #1;
			b_hold = tbl[i].hold;
			fork
				drive_aw(i, (tbl[i].skew < 0) ? -tbl[i].skew : 0);
				drive_w(i, (tbl[i].skew > 0) ? tbl[i].skew : 0);
			join
			if (tbl[i].hold && !tbl[i + 1].hold)
			begin
				repeat (12) @(posedge i_clk) #1;
				assert (!o_axi_awready && !o_axi_wready) else
				begin
					other++;
					$display("Readies still high with a full response queue");
				end
				assert (stb_count == 12) else
				begin
					mism++;
					$display("MISMATCH stb_count got %h exp %h", stb_count, 12);
				end
				b_hold = 1'b0;
			end
		end
		while (b_count < N)
			@(posedge i_clk) #1;
		repeat (4) @(posedge i_clk);
		assert (stb_count == N) else
		begin
			mism++;
			$display("MISMATCH stb_count got %h exp %h", stb_count, N);
		end
		prop_fail = dut0.u_tracker.u_props.fail_count;
		$display("Errors: %0d mismatches, %0d other, %0d property", mism, other, prop_fail);
		if ((mism == 0) && (other == 0) && (prop_fail == 0))
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

//--- tests/axilwr2wb_props.sv
// Bound into axil_resp_tracker; checks queue limit, B channel hold and drain blocking only
module axilwr2wb_props (
	input logic i_clk,
	input logic w_reset,
	input logic i_accept,
	input logic i_axi_bready,
	input logic o_slot_free,
	input logic o_axi_bvalid,
	input axil_wb_pkg::axi_resp_e o_axi_bresp,
	input axil_wb_pkg::resp_ptr_t r_first,
	input axil_wb_pkg::resp_ptr_t r_last,
	input axil_wb_pkg::trk_state_e r_state
);
	timeunit 1ns;
	timeprecision 100ps;

	// Entries accepted but not yet answered
	axil_wb_pkg::resp_ptr_t w_fill;
	assign w_fill = r_first - r_last;

	// Failed properties so far
	int fail_count = 0;

	// A full queue takes no more writes
	full_blocks: assert property (@(posedge i_clk) disable iff (w_reset)
		(w_fill == axil_wb_pkg::RESP_DEPTH) |-> !o_slot_free)
		else
		begin
			$error("slot free with a full response queue");
			fail_count++;
		end

	// B beat holds until taken
	b_holds: assert property (@(posedge i_clk) disable iff (w_reset)
		(o_axi_bvalid && !i_axi_bready) |=> (o_axi_bvalid && $stable(o_axi_bresp)))
		else
		begin
			$error("bvalid or bresp changed while bready low");
			fail_count++;
		end

	// Flushing blocks new writes
	drain_no_accept: assert property (@(posedge i_clk) disable iff (w_reset)
		!((r_state == axil_wb_pkg::TRK_DRAIN) && i_accept))
		else
		begin
			$error("write accepted during error drain");
			fail_count++;
		end

endmodule

bind axil_resp_tracker axilwr2wb_props u_props (.*);

//--- source/axilwr2wb.sv
// AXI-lite write-only slave to pipelined Wishbone master; no read channel and no protection bits
module axilwr2wb (
	input logic i_clk,
	input logic w_reset,
	// AXI-lite write address
	input logic i_axi_awvalid,
	output logic o_axi_awready,
	input logic [axil_wb_pkg::AXI_ADDR_W-1:0] i_axi_awaddr,
	// AXI-lite write data
	input logic i_axi_wvalid,
	output logic o_axi_wready,
	input logic [axil_wb_pkg::DATA_W-1:0] i_axi_wdata,
	input logic [axil_wb_pkg::STRB_W-1:0] i_axi_wstrb,
	// AXI-lite write response
	output logic o_axi_bvalid,
	input logic i_axi_bready,
	output axil_wb_pkg::axi_resp_e o_axi_bresp,
	// Wishbone master
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output logic [axil_wb_pkg::WB_ADDR_W-1:0] o_wb_addr,
	output logic [axil_wb_pkg::DATA_W-1:0] o_wb_data,
	output logic [axil_wb_pkg::STRB_W-1:0] o_wb_sel,
	input logic i_wb_ack,
	input logic i_wb_stall,
	input logic i_wb_err
);

	// Joined request toward the master
	logic w_accept;
	axil_wb_pkg::wb_req_t w_req;

	// Issue path status
	logic w_issue_ready;
	logic w_slot_free;

	// Completion events
	logic w_done;
	logic w_bus_err;

	////////////////////////////////////////////////////////////
	// AW and W join
	////////////////////////////////////////////////////////////

	axil_write_join u_join (
		.i_clk(i_clk),
		.w_reset(w_reset),
		.i_axi_awvalid(i_axi_awvalid),
		.o_axi_awready(o_axi_awready),
		.i_axi_awaddr(i_axi_awaddr),
		.i_axi_wvalid(i_axi_wvalid),
		.o_axi_wready(o_axi_wready),
		.i_axi_wdata(i_axi_wdata),
		.i_axi_wstrb(i_axi_wstrb),
		.i_can_issue({w_issue_ready, w_slot_free}),
		.o_accept(w_accept),
		.o_req(w_req)
	);

	// Wishbone side
	wb_write_master u_master (
		.i_clk(i_clk),
		.w_reset(w_reset),
		.i_accept(w_accept),
		.i_req(w_req),
		.o_issue_ready(w_issue_ready),
		.o_wb_cyc(o_wb_cyc),
		.o_wb_stb(o_wb_stb),
		.o_wb_addr(o_wb_addr),
		.o_wb_data(o_wb_data),
		.o_wb_sel(o_wb_sel),
		.i_wb_ack(i_wb_ack),
		.i_wb_stall(i_wb_stall),
		.i_wb_err(i_wb_err),
		.o_done(w_done),
		.o_bus_err(w_bus_err)
	);

	// Response ordering and error flush
	axil_resp_tracker u_tracker (
		.i_clk(i_clk),
		.w_reset(w_reset),
		.i_accept(w_accept),
		.i_done(w_done),
		.i_bus_err(w_bus_err),
		.o_slot_free(w_slot_free),
		.o_axi_bvalid(o_axi_bvalid),
		.i_axi_bready(i_axi_bready),
		.o_axi_bresp(o_axi_bresp)
	);

endmodule

//--- source/axil_resp_tracker.sv
// In-order B channel for up to eight writes; after a bus error new writes wait until the queue drains
module axil_resp_tracker (
	input logic i_clk,
	input logic w_reset,
	// Queue events
	input logic i_accept,
	input logic i_done,
	input logic i_bus_err,
	// Room for another write
	output logic o_slot_free,
	// AXI-lite write response
	output logic o_axi_bvalid,
	input logic i_axi_bready,
	output axil_wb_pkg::axi_resp_e o_axi_bresp
);

	// first is accepted, mid is finished on the bus, last is answered
	axil_wb_pkg::resp_ptr_t r_first;
	axil_wb_pkg::resp_ptr_t r_mid;
	axil_wb_pkg::resp_ptr_t r_last;

	// Entry that took the bus error
	axil_wb_pkg::resp_ptr_t r_err_loc;

	logic r_full;
	axil_wb_pkg::trk_state_e r_state;

	// Derived values
	axil_wb_pkg::resp_ptr_t w_next_first;
	axil_wb_pkg::resp_ptr_t w_fill_next;
	axil_wb_pkg::resp_ptr_t w_err_dist;
	logic w_pop;

	////////////////////////////////////////////////////////////
	// Queue pointers
	////////////////////////////////////////////////////////////

	assign w_pop = o_axi_bvalid && i_axi_bready;
	assign w_next_first = r_first + 1'b1;
	assign w_fill_next = w_next_first - r_last;

	always_ff @(posedge i_clk)
	begin
		if (w_reset)
		begin
			r_first <= '0;
			r_mid <= '0;
			r_last <= '0;
		end
		else
		begin
			if (i_accept)
				r_first <= w_next_first;

			// Bus completions first, then flushing toward first
			if (i_done)
				r_mid <= r_mid + 1'b1;
			else if ((r_state == axil_wb_pkg::TRK_DRAIN) && (r_mid != r_first))
				r_mid <= r_mid + 1'b1;

			if (w_pop)
				r_last <= r_last + 1'b1;
		end
	end

	// Full once RESP_DEPTH entries are waiting
	always_ff @(posedge i_clk)
	begin
		if (w_reset)
			r_full <= 1'b0;
		else if (i_accept && !w_pop)
			r_full <= (w_fill_next == axil_wb_pkg::RESP_DEPTH);
		else if (w_pop && !i_accept)
			r_full <= 1'b0;
	end

	////////////////////////////////////////////////////////////
	// Error drain
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (w_reset)
		begin
			r_state <= axil_wb_pkg::TRK_RUN;
			r_err_loc <= '0;
		end
		else if (i_bus_err)
		begin
			// The erroring write sits at mid
			r_state <= axil_wb_pkg::TRK_DRAIN;
			r_err_loc <= r_mid;
		end
		else if ((r_state == axil_wb_pkg::TRK_DRAIN) && (r_first == r_last))
			r_state <= axil_wb_pkg::TRK_RUN;
	end

	// No new writes while full or flushing
	assign o_slot_free = !r_full && (r_state == axil_wb_pkg::TRK_RUN);

	////////////////////////////////////////////////////////////
	// B channel
	////////////////////////////////////////////////////////////

	// Answer ready whenever mid is ahead of last
	assign o_axi_bvalid = (r_mid != r_last);

	// Wrap distance, top bit set means last is past the error entry
	assign w_err_dist = r_err_loc - r_last;

	always_comb
	begin
		if (r_state == axil_wb_pkg::TRK_RUN)
			o_axi_bresp = axil_wb_pkg::RESP_OKAY;
		else if (w_err_dist == '0)
			o_axi_bresp = axil_wb_pkg::RESP_SLVERR;
		else if (w_err_dist[axil_wb_pkg::LGFIFO])
			o_axi_bresp = axil_wb_pkg::RESP_DECERR;
		else
			o_axi_bresp = axil_wb_pkg::RESP_OKAY;   // acked before the error
	end

endmodule

//--- source/wb_write_master.sv
// Pipelined Wishbone write master; expects one ack or err per accepted stb and no ack outside cyc
module wb_write_master (
	input logic i_clk,
	input logic w_reset,
	// Request from the join
	input logic i_accept,
	input axil_wb_pkg::wb_req_t i_req,
	output logic o_issue_ready,
	// Wishbone master side
	output logic o_wb_cyc,
	output logic o_wb_stb,
	output logic [axil_wb_pkg::WB_ADDR_W-1:0] o_wb_addr,
	output logic [axil_wb_pkg::DATA_W-1:0] o_wb_data,
	output logic [axil_wb_pkg::STRB_W-1:0] o_wb_sel,
	input logic i_wb_ack,
	input logic i_wb_stall,
	input logic i_wb_err,
	// Completion events for the tracker
	output logic o_done,
	output logic o_bus_err
);

	// Registered request on the bus
	axil_wb_pkg::wb_req_t r_req;

	// Acks still owed by the slave
	axil_wb_pkg::resp_ptr_t r_outstanding;

	logic w_stb_taken;

	////////////////////////////////////////////////////////////
	// Handshake decode
	////////////////////////////////////////////////////////////

	// Slave took the strobe this cycle
	assign w_stb_taken = o_wb_stb && !i_wb_stall;

	// A new request may load when nothing is waiting on stall
	assign o_issue_ready = !o_wb_stb || !i_wb_stall;

	// Bus responses only count while the cycle is open
	assign o_done = o_wb_cyc && (i_wb_ack || i_wb_err);
	assign o_bus_err = o_wb_cyc && i_wb_err;

	// Cycle stays open until every strobe is answered
	assign o_wb_cyc = o_wb_stb || (r_outstanding != '0);

	////////////////////////////////////////////////////////////
	// Strobe and request
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		// An error ends the cycle, even over a fresh accept
		if (w_reset || o_bus_err)
			o_wb_stb <= 1'b0;
		else if (i_accept)
			o_wb_stb <= 1'b1;
		else if (!i_wb_stall)
			o_wb_stb <= 1'b0;
	end

	// Request holds still under stall
	always_ff @(posedge i_clk)
	begin
		if (o_issue_ready)
			r_req <= i_req;
	end

	assign o_wb_addr = r_req.addr;
	assign o_wb_data = r_req.data;
	assign o_wb_sel = r_req.sel;

	////////////////////////////////////////////////////////////
	// Outstanding ack count
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (w_reset || o_bus_err)
			r_outstanding <= '0;
		else
		begin
			// Moves by one at most, strobe and ack together cancel
			case ({w_stb_taken, o_wb_cyc && i_wb_ack})
				2'b10: r_outstanding <= r_outstanding + 1'b1;
				2'b01: r_outstanding <= r_outstanding - 1'b1;
				default: r_outstanding <= r_outstanding;
			endcase
		end
	end

endmodule

//--- source/axil_write_join.sv
// Holds one AW and one W beat at most; i_can_issue bit 1 is Wishbone ready and bit 0 a free response slot
module axil_write_join (
	input logic i_clk,
	input logic w_reset,
	// AXI-lite write address
	input logic i_axi_awvalid,
	output logic o_axi_awready,
	input logic [axil_wb_pkg::AXI_ADDR_W-1:0] i_axi_awaddr,
	// AXI-lite write data
	input logic i_axi_wvalid,
	output logic o_axi_wready,
	input logic [axil_wb_pkg::DATA_W-1:0] i_axi_wdata,
	input logic [axil_wb_pkg::STRB_W-1:0] i_axi_wstrb,
	// Issue path status from master and tracker
	input logic [1:0] i_can_issue,
	// Joined request out
	output logic o_accept,
	output axil_wb_pkg::wb_req_t o_req
);

	// Holding register flags
	logic r_awvalid;
	logic r_wvalid;

	// Holding register payload
	logic [axil_wb_pkg::WB_ADDR_W-1:0] r_addr;
	logic [axil_wb_pkg::DATA_W-1:0] r_data;
	logic [axil_wb_pkg::STRB_W-1:0] r_strb;

	// Handshakes and availability
	logic w_aw_take;
	logic w_w_take;
	logic w_aw_avail;
	logic w_w_avail;
	logic w_issue_ok;

	////////////////////////////////////////////////////////////
	// Ready and accept
	////////////////////////////////////////////////////////////

	// A channel is ready exactly when its holding register is empty
	assign o_axi_awready = !r_awvalid;
	assign o_axi_wready = !r_wvalid;

	assign w_aw_take = i_axi_awvalid && o_axi_awready;
	assign w_w_take = i_axi_wvalid && o_axi_wready;

	// Held beat or one arriving this cycle
	assign w_aw_avail = r_awvalid || w_aw_take;
	assign w_w_avail = r_wvalid || w_w_take;

	// Single place where the leave condition is formed
	assign w_issue_ok = i_can_issue[1] && i_can_issue[0];
	assign o_accept = w_aw_avail && w_w_avail && w_issue_ok;

	////////////////////////////////////////////////////////////
	// Holding registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (w_reset)
		begin
			r_awvalid <= 1'b0;
			r_wvalid <= 1'b0;
		end
		else
		begin
			// Arriving beat is kept only if the pair cannot leave now
			if (w_aw_take)
				r_awvalid <= !o_accept;
			else if (o_accept)
				r_awvalid <= 1'b0;

			if (w_w_take)
				r_wvalid <= !o_accept;
			else if (o_accept)
				r_wvalid <= 1'b0;
		end
	end

	// Payload capture, byte offset dropped here
	always_ff @(posedge i_clk)
	begin
		if (w_aw_take)
			r_addr <= i_axi_awaddr[axil_wb_pkg::AXI_ADDR_W-1:axil_wb_pkg::ADDR_LSBS];
		if (w_w_take)
		begin
			r_data <= i_axi_wdata;
			r_strb <= i_axi_wstrb;
		end
	end

	// Held copy wins over the live inputs
	always_comb
	begin
		o_req.addr = r_awvalid ? r_addr
			: i_axi_awaddr[axil_wb_pkg::AXI_ADDR_W-1:axil_wb_pkg::ADDR_LSBS];
		o_req.data = r_wvalid ? r_data : i_axi_wdata;
		o_req.sel = r_wvalid ? r_strb : i_axi_wstrb;
	end

endmodule

//--- source/axil_wb_pkg.sv
// Bridge types for 32-bit data, 28-bit byte addresses and at most eight writes awaiting a response
package axil_wb_pkg;

	////////////////////////////////////////////////////////////
	// Bus widths
	////////////////////////////////////////////////////////////

	// AXI-lite byte address
	localparam int AXI_ADDR_W = 28;
	// Data and byte strobes
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;
	// Byte offset bits inside one data word
	localparam int ADDR_LSBS = 2;
	// Wishbone carries word addresses only
	localparam int WB_ADDR_W = AXI_ADDR_W - ADDR_LSBS;

	////////////////////////////////////////////////////////////
	// Response queue
	////////////////////////////////////////////////////////////

	localparam int LGFIFO = 3;
	localparam int RESP_DEPTH = 1 << LGFIFO;

	// Extra top bit tells a full queue from an empty one
	typedef logic [LGFIFO:0] resp_ptr_t;

	// One Wishbone write request, 62 bits
	typedef struct packed {
		logic [WB_ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] sel;
	} wb_req_t;

	// AXI BRESP encodings
	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_SLVERR = 2'b10,
		RESP_DECERR = 2'b11
	} axi_resp_e;

	// Normal running, or flushing after a bus error
	typedef enum logic {
		TRK_RUN = 1'b0,
		TRK_DRAIN = 1'b1
	} trk_state_e;

endpackage
